/* verilog/branch_pred_pkg.sv */
// Shared types and helpers for the branch prediction unit.
// Holds the PC width, the PC and history-counter types and the
// saturating counter advance used by the update path.

package branch_pred_pkg;

  localparam int PC_WIDTH = 16;            // Instruction address width

  typedef logic [PC_WIDTH-1:0] pc_t;       // Instruction address / branch target

  // Two-bit history state, bit 1 set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'd0,                      // Strongly not taken
    WEAK_NT   = 2'd1,                      // Weakly not taken
    WEAK_T    = 2'd2,                      // Weakly taken
    STRONG_T  = 2'd3                       // Strongly taken
  } counter_t;

  //////////////////////////////////////////////////
  // Saturating two-bit counter advance
  //////////////////////////////////////////////////
  function automatic counter_t next_counter(
    input counter_t cur,                   // State the branch was predicted with
    input logic     taken                  // Resolved outcome
  );
    counter_t nxt;
    unique case (cur)
      STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT; // Floor at 0
      WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;    // Ceiling at 3
    endcase
    return nxt;
  endfunction

endpackage

/* verilog/pred_update_if.sv */
// One table write from the update controller to the lookup tables.
// The ctrl side drives the strobes and entry fields, the tbl side
// consumes them at the next rising clock edge.

interface pred_update_if #(
  parameter int INDEX_BITS = 3             // Table index width
);

  logic                      bht_we;       // History table write strobe
  logic                      btb_we;       // Target buffer write strobe
  branch_pred_pkg::pc_t      pc;           // Branch PC, gives index and tag
  branch_pred_pkg::counter_t counter;      // New history state
  branch_pred_pkg::pc_t      target;       // New branch target

  // Index field has to fit below the PC MSB and leave a tag bit
  if (INDEX_BITS < 1 || INDEX_BITS > branch_pred_pkg::PC_WIDTH - 2) begin : g_bad_index
    $error("pred_update_if: INDEX_BITS out of range");
  end

  modport ctrl (
    output bht_we, btb_we, pc, counter, target
  );

  modport tbl (
    input bht_we, btb_we, pc, counter, target
  );

endinterface

/* verilog/tagged_table.sv */
// Direct-mapped table with valid bit, tag and payload per entry.
// Index is PC[INDEX_BITS:1], tag is the PC bits above it.
// Writes land on the clock edge, reads and tag compare are combinational.

module tagged_table #(
  parameter type payload_t  = branch_pred_pkg::pc_t, // Stored entry payload
  parameter int  INDEX_BITS = 3                      // log2 of entry count
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,       // Write strobe
  input  branch_pred_pkg::pc_t wr_pc,    // Write address
  input  payload_t             wr_data,  // Write payload
  input  branch_pred_pkg::pc_t rd_pc,    // Lookup address
  output payload_t             rd_data,  // Payload at lookup index
  output logic                 hit       // Valid entry with matching tag
);

  localparam int ENTRIES  = 1 << INDEX_BITS;
  localparam int TAG_BITS = branch_pred_pkg::PC_WIDTH - INDEX_BITS - 1;
  localparam int TAG_LSB  = INDEX_BITS + 1;  // PC bit 0 is below the index

  logic [ENTRIES-1:0]  valid;              // One valid bit per entry
  logic [TAG_BITS-1:0] tags [ENTRIES];     // Upper PC bits of the writer
  payload_t            data [ENTRIES];     // Entry payloads

  logic [INDEX_BITS-1:0] wr_idx;
  logic [INDEX_BITS-1:0] rd_idx;
  logic [TAG_BITS-1:0]   wr_tag;
  logic [TAG_BITS-1:0]   rd_tag;

  assign wr_idx = wr_pc[INDEX_BITS:1];
  assign rd_idx = rd_pc[INDEX_BITS:1];
  assign wr_tag = wr_pc[branch_pred_pkg::PC_WIDTH-1:TAG_LSB];
  assign rd_tag = rd_pc[branch_pred_pkg::PC_WIDTH-1:TAG_LSB];

  //////////////////////////////////////////////////
  // Entry storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;                         // All entries empty
      for (int i = 0; i < ENTRIES; i++) begin
        data[i] <= payload_t'(0);          // Counters to 0, targets to 0
      end
    end else if (we) begin
      valid[wr_idx] <= 1'b1;
      tags[wr_idx]  <= wr_tag;
      data[wr_idx]  <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign rd_data = data[rd_idx];                               // Raw payload, no gating
  assign hit     = valid[rd_idx] && (tags[rd_idx] == rd_tag);  // Tag hit on a live entry

endmodule

/* verilog/branch_update_ctrl.sv */
// Decode-side update path of the branch predictor.
// Qualifies the resolution strobes with enable and presents one table
// write per cycle, carrying the advanced history counter.

module branch_update_ctrl #(
  parameter int INDEX_BITS = 3             // Table index width
) (
  input  logic                      enable,           // Predictor enable
  input  branch_pred_pkg::pc_t      if_id_pc,         // PC of the resolved branch
  input  branch_pred_pkg::counter_t if_id_prediction, // Counter it was predicted with
  input  logic                      wen_bht,          // Decode asks for history write
  input  logic                      wen_btb,          // Decode asks for target write
  input  logic                      actual_taken,     // Resolved outcome
  input  branch_pred_pkg::pc_t      actual_target,    // Resolved target
  pred_update_if.ctrl               upd               // Write port towards the tables
);

  // Same index range rule as the tables behind the interface
  if (INDEX_BITS < 1 || INDEX_BITS > branch_pred_pkg::PC_WIDTH - 2) begin : g_bad_index
    $error("branch_update_ctrl: INDEX_BITS out of range");
  end

  //////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////
  assign upd.bht_we = enable & wen_bht;    // No writes while disabled
  assign upd.btb_we = enable & wen_btb;

  //////////////////////////////////////////////////
  // Entry contents
  //////////////////////////////////////////////////
  assign upd.pc      = if_id_pc;           // Index and tag come from the branch PC
  assign upd.target  = actual_target;

  // Advance from the state used at fetch, not a fresh table read
  assign upd.counter = branch_pred_pkg::next_counter(if_id_prediction, actual_taken);

endmodule

/* verilog/branch_lookup.sv */
// Fetch-side lookup of the branch predictor.
// Holds the history table and the target buffer, takes their writes
// from the update interface and forms the three predictions for pc_curr.
// Outputs are gated by enable and by a write in flight to the same table.

module branch_lookup #(
  parameter int INDEX_BITS = 3             // Table index width
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable,           // Predictor enable
  input  branch_pred_pkg::pc_t      pc_curr,          // Fetch PC
  pred_update_if.tbl                upd,              // Writes from the update path
  output logic                      predicted_taken,  // Tag hit on a taken state
  output branch_pred_pkg::counter_t prediction,       // Stored history counter
  output branch_pred_pkg::pc_t      predicted_target  // Target on a buffer hit
);

  branch_pred_pkg::counter_t bht_data;     // Raw history entry
  logic                      bht_hit;
  branch_pred_pkg::pc_t      btb_data;     // Raw target entry
  logic                      btb_hit;
  logic                      bht_rd_ok;    // History outputs may show data
  logic                      btb_rd_ok;    // Target output may show data

  //////////////////////////////////////////////////
  // Branch history table
  //////////////////////////////////////////////////
  tagged_table #(
    .payload_t  (branch_pred_pkg::counter_t),
    .INDEX_BITS (INDEX_BITS)
  ) u_bht (
    .clk     (clk),
    .rst     (rst),
    .we      (upd.bht_we),
    .wr_pc   (upd.pc),
    .wr_data (upd.counter),
    .rd_pc   (pc_curr),
    .rd_data (bht_data),
    .hit     (bht_hit)
  );

  //////////////////////////////////////////////////
  // Branch target buffer
  //////////////////////////////////////////////////
  tagged_table #(
    .payload_t  (branch_pred_pkg::pc_t),
    .INDEX_BITS (INDEX_BITS)
  ) u_btb (
    .clk     (clk),
    .rst     (rst),
    .we      (upd.btb_we),
    .wr_pc   (upd.pc),
    .wr_data (upd.target),
    .rd_pc   (pc_curr),
    .rd_data (btb_data),
    .hit     (btb_hit)
  );

  //////////////////////////////////////////////////
  // Prediction outputs
  //////////////////////////////////////////////////
  assign bht_rd_ok = enable & ~upd.bht_we; // Hide history while it is being written
  assign btb_rd_ok = enable & ~upd.btb_we; // Same for the target buffer

  // Counter is shown even on a tag miss, only the taken bit needs the hit
  assign prediction = bht_rd_ok ? bht_data : branch_pred_pkg::STRONG_NT;

  assign predicted_taken = bht_rd_ok & bht_hit & bht_data[1]; // Bit 1 is the taken half

  assign predicted_target = (btb_rd_ok && btb_hit) ? btb_data : '0;

endmodule

/* verilog/branch_predictor.sv */
// Top level of the branch prediction unit.
// Fetch presents pc_curr and gets a same-cycle prediction, decode
// returns the resolved branch and the tables update on the next edge.

module branch_predictor #(
  parameter int INDEX_BITS = 3             // Table index width, 8 entries by default
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable,           // Predictor enable
  input  branch_pred_pkg::pc_t      pc_curr,          // Fetch PC
  input  branch_pred_pkg::pc_t      if_id_pc,         // Resolved branch PC
  input  branch_pred_pkg::counter_t if_id_prediction, // Counter used at fetch
  input  logic                      wen_bht,          // History write request
  input  logic                      wen_btb,          // Target write request
  input  logic                      actual_taken,     // Resolved outcome
  input  branch_pred_pkg::pc_t      actual_target,    // Resolved target
  output logic                      predicted_taken,
  output branch_pred_pkg::counter_t prediction,
  output branch_pred_pkg::pc_t      predicted_target
);

  pred_update_if #(.INDEX_BITS(INDEX_BITS)) upd_if (); // Update path to the tables

  //////////////////////////////////////////////////
  // Decode-side update
  //////////////////////////////////////////////////
  branch_update_ctrl #(
    .INDEX_BITS (INDEX_BITS)
  ) u_update_ctrl (
    .enable           (enable),
    .if_id_pc         (if_id_pc),
    .if_id_prediction (if_id_prediction),
    .wen_bht          (wen_bht),
    .wen_btb          (wen_btb),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .upd              (upd_if.ctrl)
  );

  //////////////////////////////////////////////////
  // Fetch-side lookup
  //////////////////////////////////////////////////
  branch_lookup #(
    .INDEX_BITS (INDEX_BITS)
  ) u_lookup (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc_curr          (pc_curr),
    .upd              (upd_if.tbl),
    .predicted_taken  (predicted_taken),
    .prediction       (prediction),
    .predicted_target (predicted_target)
  );

endmodule

/* verif/bp_clock_gen.sv */
// Clock and reset source for the branch predictor testbench.
// Free-running clock, reset held high for a fixed number of rising edges.

module bp_clock_gen #(
  parameter int PERIOD       = 8,          // Clock period in time units
  parameter int RESET_CYCLES = 5           // Rising edges with reset high
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;      // 50 percent duty cycle
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;                         // Release just after the edge
  end

endmodule

/* verif/branch_predictor_properties.sv */
// Concurrent checks on the branch predictor top-level ports.
// Bound into every branch_predictor instance by the bind at the bottom.

module branch_predictor_properties (
  input logic                      clk,
  input logic                      rst,
  input logic                      enable,
  input logic                      wen_bht,
  input logic                      predicted_taken,
  input branch_pred_pkg::counter_t prediction,
  input branch_pred_pkg::pc_t      predicted_target
);

  // Disabled unit shows nothing at all
  a_disabled_quiet: assert property (@(posedge clk) disable iff (rst)
    !enable |-> (!predicted_taken && prediction == branch_pred_pkg::STRONG_NT &&
                 predicted_target == '0))
    else $error("Outputs not zero while enable is low");

  // A taken prediction always comes from a taken-half counter
  a_taken_from_counter: assert property (@(posedge clk) disable iff (rst)
    predicted_taken |-> prediction[1])
    else $error("predicted_taken set with counter bit 1 clear");

  // History being written is hidden in the same cycle
  a_write_hides_history: assert property (@(posedge clk) disable iff (rst)
    (enable && wen_bht) |-> prediction == branch_pred_pkg::STRONG_NT)
    else $error("prediction not zero during a history write");

endmodule

bind branch_predictor branch_predictor_properties u_props (
  .clk              (clk),
  .rst              (rst),
  .enable           (enable),
  .wen_bht          (wen_bht),
  .predicted_taken  (predicted_taken),
  .prediction       (prediction),
  .predicted_target (predicted_target)
);

/* verif/branch_predictor_tb.sv */
// Directed testbench for the branch prediction unit.
// Each test is a task that drives the DUT cycle by cycle and compares the
// outputs with a table model, the error count is printed at the end.

module branch_predictor_tb;

  localparam int INDEX_BITS = 3;
  localparam int ENTRIES    = 1 << INDEX_BITS;
  localparam int TAG_LSB    = INDEX_BITS + 1;  // Tag is the PC above the index

  logic                      clk;
  logic                      rst;
  logic                      enable;
  branch_pred_pkg::pc_t      pc_curr;
  branch_pred_pkg::pc_t      if_id_pc;
  branch_pred_pkg::counter_t if_id_prediction;
  logic                      wen_bht;
  logic                      wen_btb;
  logic                      actual_taken;
  branch_pred_pkg::pc_t      actual_target;
  logic                      predicted_taken;
  branch_pred_pkg::counter_t prediction;
  branch_pred_pkg::pc_t      predicted_target;

  // Table model, one entry per index
  logic              bht_valid [ENTRIES];
  logic [15:TAG_LSB] bht_tag   [ENTRIES];
  logic [1:0]        bht_ctr   [ENTRIES];
  logic              btb_valid [ENTRIES];
  logic [15:TAG_LSB] btb_tag   [ENTRIES];
  logic [15:0]       btb_tgt   [ENTRIES];

  int     errors;
  integer seed;                                // Random stream state
  bit     released;

  bp_clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clk_gen (.clk(clk), .rst(rst));

  branch_predictor #(.INDEX_BITS(INDEX_BITS)) UUT (.*);

  // Up one on taken, down one otherwise, held at 0 and 3
  function automatic logic [1:0] saturate_step(input logic [1:0] cur, input logic taken);
    if (taken) begin
      return (cur == 2'd3) ? cur : cur + 2'd1;
    end else begin
      return (cur == 2'd0) ? cur : cur - 2'd1;
    end
  endfunction

  task automatic check_value(input string test, input string sig,
                             input logic [15:0] exp, input logic [15:0] act);
    assert (act == exp) else begin
      $display("[ERROR] %s: %s expected 'h%0h, actual 'h%0h", test, sig, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs(input string test);
    logic [INDEX_BITS-1:0] idx;
    logic                  bht_ok;
    logic                  btb_ok;
    logic                  exp_taken;
    logic [1:0]            exp_pred;
    logic [15:0]           exp_tgt;
    #1;                                        // Lookup settles after the drive
    idx       = pc_curr[INDEX_BITS:1];
    bht_ok    = enable && !wen_bht;            // Write in flight hides history
    btb_ok    = enable && !wen_btb;
    exp_pred  = bht_ok ? bht_ctr[idx] : 2'd0;  // Counter shown even on a tag miss
    exp_taken = bht_ok && bht_valid[idx] && bht_ctr[idx][1] &&
                (bht_tag[idx] == pc_curr[15:TAG_LSB]);
    exp_tgt   = (btb_ok && btb_valid[idx] && btb_tag[idx] == pc_curr[15:TAG_LSB]) ?
                btb_tgt[idx] : 16'h0;
    check_value(test, "prediction", 16'(exp_pred), 16'(prediction));
    check_value(test, "predicted_taken", 16'(exp_taken), 16'(predicted_taken));
    check_value(test, "predicted_target", exp_tgt, predicted_target);
  endtask

  // Model takes the same write as the DUT edge, then inputs move 1 unit later
  task automatic next_cycle();
    logic [INDEX_BITS-1:0] widx;
    widx = if_id_pc[INDEX_BITS:1];
    if (enable && wen_bht) begin
      bht_valid[widx] = 1'b1;
      bht_tag[widx]   = if_id_pc[15:TAG_LSB];
      bht_ctr[widx]   = saturate_step(if_id_prediction, actual_taken);
    end
    if (enable && wen_btb) begin
      btb_valid[widx] = 1'b1;
      btb_tag[widx]   = if_id_pc[15:TAG_LSB];
      btb_tgt[widx]   = actual_target;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    enable           = 1'b1;
    pc_curr          = 16'h0;
    if_id_pc         = 16'h0;
    if_id_prediction = branch_pred_pkg::STRONG_NT;
    wen_bht          = 1'b0;
    wen_btb          = 1'b0;
    actual_taken     = 1'b0;
    actual_target    = 16'h0;
  endtask

  task automatic wait_reset(output bit ok);
    int cycles;
    cycles = 0;
    @(posedge clk);                            // Reset source settles at time 0
    while (rst && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    ok = !rst;
  endtask

  // One resolved branch at pc, fed back with the model counter
  task automatic history_update(input string test, input branch_pred_pkg::pc_t pc,
                                input logic taken);
    pc_curr          = pc;
    if_id_pc         = pc;
    if_id_prediction = branch_pred_pkg::counter_t'(bht_ctr[pc[INDEX_BITS:1]]);
    actual_taken     = taken;
    wen_bht          = 1'b1;
    check_outputs(test);                       // Write cycle reads 0
    next_cycle();
    wen_bht = 1'b0;
    check_outputs(test);
    next_cycle();                              // Idle cycle, outputs hold
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic reset_state();
    for (int i = 0; i < 16; i++) begin
      pc_curr = 16'(i * 16'h1113);             // Walks index, tag and bit 0
      check_outputs("reset_state");
      check_value("reset_state", "all outputs", 16'h0,
                  predicted_target | 16'(prediction) | 16'(predicted_taken));
      next_cycle();
    end
  endtask

  task automatic counter_training();
    int steps [8] = '{1, 2, 3, 3, 2, 1, 0, 0};
    for (int i = 0; i < 8; i++) begin
      history_update("counter_training", 16'h1234, i < 4); // 4 taken, then 4 not taken
      check_value("counter_training", "prediction", 16'(steps[i]), 16'(prediction));
      check_value("counter_training", "predicted_taken", 16'(steps[i] >= 2),
                  16'(predicted_taken));
    end
  endtask

  task automatic tag_alias();
    for (int i = 0; i < 3; i++) begin
      history_update("tag_alias", 16'h1234, 1'b1); // Back up to strong taken
    end
    if_id_pc      = 16'h1234;
    actual_target = 16'hbeef;
    wen_btb       = 1'b1;
    next_cycle();
    wen_btb = 1'b0;
    pc_curr = 16'h1334;                        // Same index, other tag
    check_outputs("tag_alias");
    check_value("tag_alias", "prediction", 16'h3, 16'(prediction));
    check_value("tag_alias", "predicted_taken", 16'h0, 16'(predicted_taken));
    check_value("tag_alias", "predicted_target", 16'h0, predicted_target);
    next_cycle();
  endtask

  task automatic target_write();
    pc_curr       = 16'h2a46;
    if_id_pc      = 16'h2a46;
    actual_target = 16'h8ace;
    wen_btb       = 1'b1;
    check_outputs("target_write");
    next_cycle();
    wen_btb = 1'b0;
    check_outputs("target_write");
    check_value("target_write", "predicted_target", 16'h8ace, predicted_target);
    next_cycle();
    actual_target = 16'h1357;                  // Rewrite the live entry
    wen_btb       = 1'b1;
    check_outputs("target_write");
    check_value("target_write", "predicted_target", 16'h0, predicted_target);
    next_cycle();
    wen_btb = 1'b0;
    check_outputs("target_write");
    check_value("target_write", "predicted_target", 16'h1357, predicted_target);
    next_cycle();
  endtask

  task automatic enable_gating();
    pc_curr          = 16'h1234;
    if_id_pc         = 16'h1234;
    if_id_prediction = branch_pred_pkg::STRONG_NT;
    actual_taken     = 1'b0;
    actual_target    = 16'h1111;
    wen_bht          = 1'b1;
    wen_btb          = 1'b1;
    enable           = 1'b0;                   // Both writes must be dropped
    check_outputs("enable_gating");
    check_value("enable_gating", "all outputs", 16'h0,
                predicted_target | 16'(prediction) | 16'(predicted_taken));
    next_cycle();
    enable  = 1'b1;
    wen_bht = 1'b0;
    wen_btb = 1'b0;
    check_outputs("enable_gating");
    check_value("enable_gating", "prediction", 16'h3, 16'(prediction));
    check_value("enable_gating", "predicted_target", 16'hbeef, predicted_target);
    next_cycle();
    if_id_prediction = branch_pred_pkg::STRONG_T;
    actual_taken     = 1'b1;
    wen_bht          = 1'b1;
    check_outputs("enable_gating");
    check_value("enable_gating", "prediction", 16'h0, 16'(prediction));
    check_value("enable_gating", "predicted_taken", 16'h0, 16'(predicted_taken));
    next_cycle();
    wen_bht = 1'b0;
  endtask

  task automatic random_updates();
    logic [31:0] r1;
    logic [31:0] r2;
    for (int i = 0; i < 200; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      enable           = (r1[18:16] != 3'd0);  // Mostly enabled
      pc_curr          = {10'h0, r1[5:0]};     // Four tags over all indices
      if_id_pc         = {10'h0, r1[11:6]};
      if_id_prediction = branch_pred_pkg::counter_t'(bht_ctr[if_id_pc[INDEX_BITS:1]]);
      wen_bht          = r1[12];
      wen_btb          = r1[13];
      actual_taken     = r1[14];
      actual_target    = r2[15:0];
      check_outputs("random_updates");
      next_cycle();
    end
    drive_idle();
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    errors = 0;
    seed   = 32'h4aed;
    for (int i = 0; i < ENTRIES; i++) begin
      bht_valid[i] = 1'b0;
      bht_tag[i]   = '0;
      bht_ctr[i]   = 2'd0;
      btb_valid[i] = 1'b0;
      btb_tag[i]   = '0;
      btb_tgt[i]   = 16'h0;
    end
    drive_idle();
    wait_reset(released);
    if (!released) begin
      $display("Reset was still asserted after 50 clock cycles");
      $display("TESTS FAILED");
    end else begin
      #1;
      reset_state();
      counter_training();
      tag_alias();
      target_write();
      enable_gating();
      random_updates();
      $display("Errors: %0d", errors);
      if (errors == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
    end
    $finish;
  end

endmodule

/* src.f */
verilog/branch_pred_pkg.sv
verilog/pred_update_if.sv
verilog/tagged_table.sv
verilog/branch_update_ctrl.sv
verilog/branch_lookup.sv
verilog/branch_predictor.sv
verif/bp_clock_gen.sv
verif/branch_predictor_properties.sv
verif/branch_predictor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the branch predictor simulation with Verilator.
# Exit status is 0 only when the log shows a passing run.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=branch_predictor_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f src.f \
  --top-module branch_predictor_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"

# A failing run is judged by the log search below
"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail, see $LOG_FILE"
  exit 1
fi
